// File: cmd_params.svh
`ifndef CMD_PARAMS_SVH
`define CMD_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Exact control words
//////////////////////////////////////////////////////////////////////
`define CMD_HOLD_ON            16'hFFB1
`define CMD_HOLD_OFF           16'hFFB0
`define CMD_TRIG_RUN_ON        16'h00A1
`define CMD_TRIG_RUN_OFF       16'h00A0
`define CMD_ACQ_START_ON       16'hFFA1
`define CMD_ACQ_START_OFF      16'hFFA0
`define CMD_USB_ACQ_ON         16'hF0F1
`define CMD_USB_ACQ_OFF        16'hF0F0
`define CMD_MODE_NORMAL        16'hFD40
`define CMD_MODE_CALI          16'hFD41
`define CMD_TDC_ON             16'hF901
`define CMD_TDC_OFF            16'hF900

// Trigger source select
`define CMD_TRIG_MODE_INSIDE   16'hAA01
`define CMD_TRIG_MODE_EXT      16'hAA02
`define CMD_TRIG_MODE_SELF_OR  16'hAA03
`define CMD_TRIG_MODE_SELF_AND 16'hAA04

// Timed pulse requests
`define CMD_PULSE_CONFIG       16'h00B1
`define CMD_PULSE_REGISTER     16'h00B2
`define CMD_PULSE_RESET        16'hFFC0
`define CMD_PULSE_CONV         16'hFFD0
`define CMD_PULSE_TRIG         16'hFFE0
`define CMD_PULSE_READOUT      16'hFFE3

//////////////////////////////////////////////////////////////////////
// Code prefixes, payload in the remaining low bits
//////////////////////////////////////////////////////////////////////
`define PFX_INSIDE_TIME        8'hAB   // Word[15:8]
`define PFX_VALID_TA           12'h920 // Word[15:4]
`define PFX_FEEDBACK_CAP       12'hACA // Word[15:4]
`define PFX_TA_THR_12          4'h1    // Word[15:12]
`define PFX_TA_THR_34          4'h4
`define PFX_CALI_DAC           4'h5
`define PFX_HOLD_DELAY         4'h6
`define PFX_PROBE_ANA          8'h30
`define PFX_PROBE_THR          8'h31
`define PFX_PROBE_RES          8'h34

// Probe vector widths
`define PROBE_ANA_W            192
`define PROBE_THR_W            128
`define PROBE_RES_W            64

// Pulse lengths in clk cycles
`define LEN_CONFIG             10
`define LEN_RESET              17
`define LEN_REGISTER           12
`define LEN_CONV               4
`define LEN_TRIG               2
`define LEN_READOUT            12

`endif

// File: cmd_pkg.sv
package cmd_pkg;

  typedef logic [15:0] cmd_word_t;   // Raw USB control word
  typedef logic [11:0] cmd_arg_t;    // Payload after decode
  typedef logic [7:0]  probe_code_t; // 1-based probe index, 0 clears
  typedef logic [9:0]  dac10_t;      // TA threshold code
  typedef logic [11:0] dac12_t;      // Cali DAC or hold delay

  //////////////////////////////////////////////////////////////////////
  // Decoded command kinds
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [4:0] {
    NONE,
    // Flag pairs, arg[0] carries the new value
    FLAG_TRIG_RUN,
    FLAG_HOLD,
    FLAG_START_ACQ,
    FLAG_USB_ACQ,
    FLAG_CALI_MODE,
    FLAG_TDC,
    // Register writes
    WR_TRIG_MODE,
    WR_INSIDE_TIME,
    WR_HOLD_DELAY,
    WR_VALID_TA,
    WR_TA_THR_12,
    WR_TA_THR_34,
    WR_CALI_DAC,
    WR_FEEDBACK_CAP,
    // Probe selects
    PROBE_ANA,
    PROBE_THR,
    PROBE_RES,
    // Pulses
    PULSE_CONFIG,
    PULSE_RESET,
    PULSE_REGISTER,
    PULSE_CONV,
    PULSE_TRIG,
    PULSE_READOUT
  } cmd_kind_t;

  typedef struct packed {
    cmd_kind_t kind;
    cmd_arg_t  arg;
  } cmd_t;

  typedef struct packed {
    logic [3:0] trig_mode;   // One-hot source
    logic [7:0] inside_time;
    dac12_t     hold_delay;
    logic [3:0] valid_ta;    // TA mask for self trigger
  } trig_cfg_t;

  typedef struct packed {
    logic trig_run;
    logic hold;
    logic start_acq;
    logic usb_acq;
    logic cali_mode;
    logic tdc_on;
  } run_ctrl_t;

  typedef struct packed {
    dac10_t     ta_thr_12;
    dac10_t     ta_thr_34;
    dac12_t     cali_dac;
    logic [1:0] sel_cali_ta;
    logic [3:0] feedback_cap;
  } dac_cfg_t;

  typedef enum logic {IDLE, ACTIVE} pulse_state_t;

endpackage

// File: cmd_decoder.sv
`timescale 1ns/1ps
`include "cmd_params.svh"

module cmd_decoder (
  input  logic               cmd_valid,
  input  cmd_pkg::cmd_word_t cmd_word,
  output cmd_pkg::cmd_t      cmd
);
  import cmd_pkg::*;

  always_comb
  begin
    cmd.kind = NONE;
    cmd.arg  = '0;
    if (cmd_valid)
    begin
      case (cmd_word)
        ////////////////////////////////////////////////////////////////////
        // Exact codes first
        ////////////////////////////////////////////////////////////////////
        `CMD_TRIG_RUN_ON, `CMD_TRIG_RUN_OFF:
        begin
          cmd.kind = FLAG_TRIG_RUN;
          cmd.arg  = {11'b0, cmd_word == `CMD_TRIG_RUN_ON};
        end
        `CMD_HOLD_ON, `CMD_HOLD_OFF:
        begin
          cmd.kind = FLAG_HOLD;
          cmd.arg  = {11'b0, cmd_word == `CMD_HOLD_ON};
        end
        `CMD_ACQ_START_ON, `CMD_ACQ_START_OFF:
        begin
          cmd.kind = FLAG_START_ACQ;
          cmd.arg  = {11'b0, cmd_word == `CMD_ACQ_START_ON};
        end
        `CMD_USB_ACQ_ON, `CMD_USB_ACQ_OFF:
        begin
          cmd.kind = FLAG_USB_ACQ;
          cmd.arg  = {11'b0, cmd_word == `CMD_USB_ACQ_ON};
        end
        `CMD_MODE_NORMAL, `CMD_MODE_CALI:
        begin
          cmd.kind = FLAG_CALI_MODE;
          cmd.arg  = {11'b0, cmd_word == `CMD_MODE_CALI};
        end
        `CMD_TDC_ON, `CMD_TDC_OFF:
        begin
          cmd.kind = FLAG_TDC;
          cmd.arg  = {11'b0, cmd_word == `CMD_TDC_ON};
        end
        `CMD_TRIG_MODE_INSIDE, `CMD_TRIG_MODE_EXT,
        `CMD_TRIG_MODE_SELF_OR, `CMD_TRIG_MODE_SELF_AND:
        begin
          cmd.kind = WR_TRIG_MODE;
          cmd.arg  = {9'b0, cmd_word[2:0]}; // 1..4
        end
        `CMD_PULSE_CONFIG:   cmd.kind = PULSE_CONFIG;
        `CMD_PULSE_REGISTER: cmd.kind = PULSE_REGISTER;
        `CMD_PULSE_RESET:    cmd.kind = PULSE_RESET;
        `CMD_PULSE_CONV:     cmd.kind = PULSE_CONV;
        `CMD_PULSE_TRIG:     cmd.kind = PULSE_TRIG;
        `CMD_PULSE_READOUT:  cmd.kind = PULSE_READOUT;
        default:
        begin
          // Prefix codes, probe bytes ahead of the nibble codes
          if (cmd_word[15:8] == `PFX_INSIDE_TIME)
          begin
            cmd.kind = WR_INSIDE_TIME;
            cmd.arg  = {4'b0, cmd_word[7:0]};
          end
          else if (cmd_word[15:4] == `PFX_VALID_TA)
          begin
            cmd.kind = WR_VALID_TA;
            cmd.arg  = {8'b0, cmd_word[3:0]};
          end
          else if (cmd_word[15:4] == `PFX_FEEDBACK_CAP)
          begin
            cmd.kind = WR_FEEDBACK_CAP;
            cmd.arg  = {8'b0, cmd_word[3:0]};
          end
          else if (cmd_word[15:8] == `PFX_PROBE_ANA)
          begin
            cmd.kind = PROBE_ANA;
            cmd.arg  = {4'b0, cmd_word[7:0]};
          end
          else if (cmd_word[15:8] == `PFX_PROBE_THR)
          begin
            cmd.kind = PROBE_THR;
            cmd.arg  = {4'b0, cmd_word[7:0]};
          end
          else if (cmd_word[15:8] == `PFX_PROBE_RES)
          begin
            cmd.kind = PROBE_RES;
            cmd.arg  = {4'b0, cmd_word[7:0]};
          end
          else if (cmd_word[15:12] == `PFX_TA_THR_12)
          begin
            cmd.kind = WR_TA_THR_12;
            cmd.arg  = {2'b0, cmd_word[9:0]};
          end
          else if (cmd_word[15:12] == `PFX_TA_THR_34)
          begin
            cmd.kind = WR_TA_THR_34;
            cmd.arg  = {2'b0, cmd_word[9:0]};
          end
          else if (cmd_word[15:12] == `PFX_CALI_DAC)
          begin
            cmd.kind = WR_CALI_DAC;
            cmd.arg  = cmd_word[11:0];
          end
          else if (cmd_word[15:12] == `PFX_HOLD_DELAY)
          begin
            cmd.kind = WR_HOLD_DELAY;
            cmd.arg  = cmd_word[11:0];
          end
        end
      endcase
    end
  end

endmodule

// File: trig_config_regs.sv
`timescale 1ns/1ps

module trig_config_regs (
  input  logic               clk,
  input  logic               reset_n,
  input  cmd_pkg::cmd_t      cmd,
  output cmd_pkg::trig_cfg_t trig_cfg,
  output cmd_pkg::run_ctrl_t run_ctrl
);
  import cmd_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Trigger configuration
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      trig_cfg.trig_mode   <= 4'b0001; // Inside trigger
      trig_cfg.inside_time <= 8'd1;
      trig_cfg.hold_delay  <= 12'd1560;
      trig_cfg.valid_ta    <= 4'b1111; // All TAs in use
    end
    else
    begin
      case (cmd.kind)
        WR_TRIG_MODE:
        begin
          case (cmd.arg[2:0])
            3'd1:    trig_cfg.trig_mode <= 4'b0001; // Inside
            3'd2:    trig_cfg.trig_mode <= 4'b0010; // External
            3'd3:    trig_cfg.trig_mode <= 4'b0100; // Self OR
            3'd4:    trig_cfg.trig_mode <= 4'b1000; // Self AND
            default: trig_cfg.trig_mode <= trig_cfg.trig_mode;
          endcase
        end
        WR_INSIDE_TIME: trig_cfg.inside_time <= cmd.arg[7:0];
        WR_HOLD_DELAY:  trig_cfg.hold_delay  <= cmd.arg;
        WR_VALID_TA:    trig_cfg.valid_ta    <= cmd.arg[3:0];
        default:        trig_cfg             <= trig_cfg;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Run flags, set or cleared by arg[0]
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      run_ctrl           <= '0;
      run_ctrl.start_acq <= 1'b1;
      run_ctrl.tdc_on    <= 1'b1;
    end
    else
    begin
      case (cmd.kind)
        FLAG_TRIG_RUN:  run_ctrl.trig_run  <= cmd.arg[0];
        FLAG_HOLD:      run_ctrl.hold      <= cmd.arg[0];
        FLAG_START_ACQ: run_ctrl.start_acq <= cmd.arg[0];
        FLAG_USB_ACQ:   run_ctrl.usb_acq   <= cmd.arg[0];
        FLAG_CALI_MODE: run_ctrl.cali_mode <= cmd.arg[0];
        FLAG_TDC:       run_ctrl.tdc_on    <= cmd.arg[0];
        default:        run_ctrl           <= run_ctrl;
      endcase
    end
  end

endmodule

// File: dac_config_regs.sv
`timescale 1ns/1ps

module dac_config_regs (
  input  logic              clk,
  input  logic              reset_n,
  input  cmd_pkg::cmd_t     cmd,
  output cmd_pkg::dac_cfg_t dac_cfg
);
  import cmd_pkg::*;

  // DAC shift chain takes the MSB first, so the payload is mirrored
  function automatic dac10_t bit_reverse(input dac10_t code);
    dac10_t rev;
    for (int i = 0; i < 10; i++)
    begin
      rev[9-i] = code[i];
    end
    return rev;
  endfunction

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      dac_cfg.ta_thr_12    <= 10'h3FF;
      dac_cfg.ta_thr_34    <= 10'h3FF;
      dac_cfg.cali_dac     <= 12'h500;
      dac_cfg.sel_cali_ta  <= 2'b00;
      dac_cfg.feedback_cap <= 4'b1111;
    end
    else
    begin
      case (cmd.kind)
        WR_TA_THR_12:
        begin
          dac_cfg.ta_thr_12   <= bit_reverse(cmd.arg[9:0]);
          dac_cfg.sel_cali_ta <= 2'b10;
        end
        WR_TA_THR_34:
        begin
          dac_cfg.ta_thr_34   <= bit_reverse(cmd.arg[9:0]);
          dac_cfg.sel_cali_ta <= 2'b11;
        end
        WR_CALI_DAC:
        begin
          dac_cfg.cali_dac    <= cmd.arg;
          dac_cfg.sel_cali_ta <= 2'b00; // Back to calibration
        end
        WR_FEEDBACK_CAP: dac_cfg.feedback_cap <= cmd.arg[3:0];
        default:         dac_cfg              <= dac_cfg;
      endcase
    end
  end

endmodule

// File: probe_select.sv
`timescale 1ns/1ps

module probe_select #(
  parameter int WIDTH = 64
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 load,
  input  cmd_pkg::probe_code_t code,
  output logic [WIDTH-1:0]     sel
);

  localparam logic [WIDTH-1:0] ONE = {{(WIDTH-1){1'b0}}, 1'b1};

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      sel <= '0;
    else if (load)
    begin
      // Code 0 or past the last probe turns every probe off
      if (code == '0 || int'(code) > WIDTH)
        sel <= '0;
      else
        sel <= ONE << (code - 8'd1); // Code is 1-based
    end
  end

endmodule

// File: pulse_gen.sv
`timescale 1ns/1ps

module pulse_gen #(
  parameter int LENGTH     = 10,
  parameter bit ACTIVE_LOW = 1'b0
) (
  input  logic clk,
  input  logic reset_n,
  input  logic fire,
  output logic pulse
);
  import cmd_pkg::*;

  localparam int CNT_W = $clog2(LENGTH + 1);

  pulse_state_t     state;
  logic [CNT_W-1:0] cnt; // Cycles left after the current one

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state <= IDLE;
      cnt   <= '0;
    end
    else
    begin
      case (state)
        IDLE:
          if (fire)
          begin
            state <= ACTIVE;
            cnt   <= CNT_W'(LENGTH - 1);
          end
        ACTIVE:
          if (cnt == '0)
            state <= IDLE; // Retrigger only after this edge
          else
            cnt <= cnt - 1'b1;
        default: state <= IDLE;
      endcase
    end
  end

  assign pulse = (state == ACTIVE) ^ ACTIVE_LOW;

endmodule

// File: cmd_interp_top.sv
`timescale 1ns/1ps
`include "cmd_params.svh"

module cmd_interp_top (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    cmd_valid,
  input  cmd_pkg::cmd_word_t      cmd_word,
  output cmd_pkg::trig_cfg_t      trig_cfg,
  output cmd_pkg::run_ctrl_t      run_ctrl,
  output cmd_pkg::dac_cfg_t       dac_cfg,
  output logic [`PROBE_ANA_W-1:0] probe_ana,
  output logic [`PROBE_THR_W-1:0] probe_thr,
  output logic [`PROBE_RES_W-1:0] probe_res,
  output logic                    start_config,
  output logic                    reset_asic_b,
  output logic                    set_register,
  output logic                    start_conv_b,
  output logic                    force_trig,
  output logic                    start_readout
);
  import cmd_pkg::*;

  cmd_t cmd;

  cmd_decoder u_decoder (.cmd_valid(cmd_valid), .cmd_word(cmd_word), .cmd(cmd));

  trig_config_regs u_trig_regs (
    .clk      (clk),
    .reset_n  (reset_n),
    .cmd      (cmd),
    .trig_cfg (trig_cfg),
    .run_ctrl (run_ctrl)
  );

  dac_config_regs u_dac_regs (.clk(clk), .reset_n(reset_n), .cmd(cmd), .dac_cfg(dac_cfg));

  //////////////////////////////////////////////////////////////////////
  // Probe selects
  //////////////////////////////////////////////////////////////////////
  probe_select #(.WIDTH(`PROBE_ANA_W)) u_probe_ana (
    .clk(clk), .reset_n(reset_n), .load(cmd.kind == PROBE_ANA),
    .code(probe_code_t'(cmd.arg[7:0])), .sel(probe_ana)
  );
  probe_select #(.WIDTH(`PROBE_THR_W)) u_probe_thr (
    .clk(clk), .reset_n(reset_n), .load(cmd.kind == PROBE_THR),
    .code(probe_code_t'(cmd.arg[7:0])), .sel(probe_thr)
  );
  probe_select #(.WIDTH(`PROBE_RES_W)) u_probe_res (
    .clk(clk), .reset_n(reset_n), .load(cmd.kind == PROBE_RES),
    .code(probe_code_t'(cmd.arg[7:0])), .sel(probe_res)
  );

  //////////////////////////////////////////////////////////////////////
  // ASIC control pulses
  //////////////////////////////////////////////////////////////////////
  pulse_gen #(.LENGTH(`LEN_CONFIG), .ACTIVE_LOW(1'b0)) u_config (
    .clk(clk), .reset_n(reset_n), .fire(cmd.kind == PULSE_CONFIG), .pulse(start_config)
  );
  pulse_gen #(.LENGTH(`LEN_RESET), .ACTIVE_LOW(1'b1)) u_reset (
    .clk(clk), .reset_n(reset_n), .fire(cmd.kind == PULSE_RESET), .pulse(reset_asic_b)
  );
  pulse_gen #(.LENGTH(`LEN_REGISTER), .ACTIVE_LOW(1'b0)) u_register (
    .clk(clk), .reset_n(reset_n), .fire(cmd.kind == PULSE_REGISTER), .pulse(set_register)
  );
  pulse_gen #(.LENGTH(`LEN_CONV), .ACTIVE_LOW(1'b1)) u_conv (
    .clk(clk), .reset_n(reset_n), .fire(cmd.kind == PULSE_CONV), .pulse(start_conv_b)
  );
  pulse_gen #(.LENGTH(`LEN_TRIG), .ACTIVE_LOW(1'b0)) u_trig (
    .clk(clk), .reset_n(reset_n), .fire(cmd.kind == PULSE_TRIG), .pulse(force_trig)
  );
  pulse_gen #(.LENGTH(`LEN_READOUT), .ACTIVE_LOW(1'b0)) u_readout (
    .clk(clk), .reset_n(reset_n), .fire(cmd.kind == PULSE_READOUT), .pulse(start_readout)
  );

endmodule

// File: cmd_sva.sv
`timescale 1ns/1ps
`include "cmd_params.svh"

module cmd_sva (
  input logic                    clk,
  input logic                    reset_n,
  input logic [`PROBE_ANA_W-1:0] probe_ana,
  input logic [`PROBE_THR_W-1:0] probe_thr,
  input logic [`PROBE_RES_W-1:0] probe_res,
  input logic                    start_config,
  input logic                    reset_asic_b,
  input logic                    set_register,
  input logic                    start_conv_b,
  input logic                    force_trig,
  input logic                    start_readout
);

  int unsigned err_count = 0; // Failed assertions so far

  //////////////////////////////////////////////////////////////////////
  // Probe selects never drive two probes at once
  //////////////////////////////////////////////////////////////////////
  a_ana_onehot: assert property (@(posedge clk) disable iff (!reset_n) $onehot0(probe_ana))
  else
  begin
    $error("Analog probe select has more than one bit set");
    err_count++;
  end
  a_thr_onehot: assert property (@(posedge clk) disable iff (!reset_n) $onehot0(probe_thr))
  else
  begin
    $error("Threshold probe select has more than one bit set");
    err_count++;
  end
  a_res_onehot: assert property (@(posedge clk) disable iff (!reset_n) $onehot0(probe_res))
  else
  begin
    $error("Channel resistor select has more than one bit set");
    err_count++;
  end

  //////////////////////////////////////////////////////////////////////
  // Pulse widths from start edge to end edge
  //////////////////////////////////////////////////////////////////////
  a_config_len: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(start_config) |-> ##(`LEN_CONFIG) $fell(start_config))
  else
  begin
    $error("start_config pulse has the wrong width");
    err_count++;
  end
  a_reset_len: assert property (@(posedge clk) disable iff (!reset_n)
    $fell(reset_asic_b) |-> ##(`LEN_RESET) $rose(reset_asic_b)) // Active low
  else
  begin
    $error("reset_asic_b pulse has the wrong width");
    err_count++;
  end
  a_register_len: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(set_register) |-> ##(`LEN_REGISTER) $fell(set_register))
  else
  begin
    $error("set_register pulse has the wrong width");
    err_count++;
  end
  a_conv_len: assert property (@(posedge clk) disable iff (!reset_n)
    $fell(start_conv_b) |-> ##(`LEN_CONV) $rose(start_conv_b))
  else
  begin
    $error("start_conv_b pulse has the wrong width");
    err_count++;
  end
  a_trig_len: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(force_trig) |-> ##(`LEN_TRIG) $fell(force_trig))
  else
  begin
    $error("force_trig pulse has the wrong width");
    err_count++;
  end
  a_readout_len: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(start_readout) |-> ##(`LEN_READOUT) $fell(start_readout))
  else
  begin
    $error("start_readout pulse has the wrong width");
    err_count++;
  end

endmodule

bind cmd_interp_top cmd_sva u_sva (
  .clk           (clk),
  .reset_n       (reset_n),
  .probe_ana     (probe_ana),
  .probe_thr     (probe_thr),
  .probe_res     (probe_res),
  .start_config  (start_config),
  .reset_asic_b  (reset_asic_b),
  .set_register  (set_register),
  .start_conv_b  (start_conv_b),
  .force_trig    (force_trig),
  .start_readout (start_readout)
);

// File: cmd_tb.sv
`timescale 1ns/1ps
`include "cmd_params.svh"

module cmd_tb;
  import cmd_pkg::*;

  localparam int TIMEOUT    = 100; // Cycles allowed per wait loop
  localparam int IDLE_CHECK = 4;
  localparam int ANA_W      = `PROBE_ANA_W;

  typedef logic [ANA_W-1:0] probe_vec_t; // Widest probe with the others zero-extended

  logic                    clk;
  logic                    reset_n;
  logic                    cmd_valid;
  cmd_word_t               cmd_word;
  trig_cfg_t               trig_cfg;
  run_ctrl_t               run_ctrl;
  dac_cfg_t                dac_cfg;
  logic [`PROBE_ANA_W-1:0] probe_ana;
  logic [`PROBE_THR_W-1:0] probe_thr;
  logic [`PROBE_RES_W-1:0] probe_res;
  logic                    start_config;
  logic                    reset_asic_b;
  logic                    set_register;
  logic                    start_conv_b;
  logic                    force_trig;
  logic                    start_readout;
  logic [5:0]              pulse_on;

  cmd_interp_top dut (.*);

  // Active level of each pulse with reset and convert inverted
  assign pulse_on = {start_config, ~reset_asic_b, set_register,
                     ~start_conv_b, force_trig, start_readout};

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_trig_cfg(input string name, input trig_cfg_t exp, input trig_cfg_t act);
    if (act !== exp)
      stop_on_error($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_run_ctrl(input string name, input run_ctrl_t exp, input run_ctrl_t act);
    if (act !== exp)
      stop_on_error($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic check_dac_cfg(input string name, input dac_cfg_t exp, input dac_cfg_t act);
    if (act !== exp)
      stop_on_error($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_probe(input string name, input probe_vec_t exp, input probe_vec_t act);
    if (act !== exp)
      stop_on_error($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_pulse_len(input string name, input int exp, input int act);
    if (act !== exp)
      stop_on_error($sformatf("FAILED %s: expected %0d, actual %0d", name, exp, act));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////
  task automatic send_word(input logic valid, input cmd_word_t word);
    @(posedge clk);
    cmd_valid <= valid;
    cmd_word  <= word;
    @(posedge clk);
    cmd_valid <= 1'b0;
    @(negedge clk); // Registers show the word one cycle after acceptance
  endtask

  task automatic idle_gap();
    int n;
    n = $urandom % 4;
    repeat (n)
    begin
      @(posedge clk);
      cmd_valid <= 1'b0;
      cmd_word  <= cmd_word_t'($urandom); // Noise on the bus while not valid
    end
  endtask

  task automatic count_active_cycles(output int cnt);
    cnt = 0;
    repeat (IDLE_CHECK)
    begin
      if (pulse_on != '0)
        cnt++;
      @(negedge clk);
    end
  endtask

  task automatic probe_case(input string name, input string kind, input cmd_word_t word,
                            input int exp_code);
    probe_vec_t exp_vec;
    probe_vec_t act_vec;
    exp_vec = (exp_code == 0) ? '0 : probe_vec_t'(1) << (exp_code - 1); // 1-based code
    send_word(1'b1, word);
    case (kind)
      "ana":   act_vec = probe_vec_t'(probe_ana);
      "thr":   act_vec = probe_vec_t'(probe_thr);
      default: act_vec = probe_vec_t'(probe_res);
    endcase
    check_probe(name, exp_vec, act_vec);
  endtask

  task automatic pulse_case(input string name, input cmd_word_t word, input int exp_len);
    logic [2:0] idx;
    logic       known;
    int         len;
    known = 1'b1;
    idx   = 3'd0;
    case (word)
      `CMD_PULSE_CONFIG:   idx = 3'd5;
      `CMD_PULSE_RESET:    idx = 3'd4;
      `CMD_PULSE_REGISTER: idx = 3'd3;
      `CMD_PULSE_CONV:     idx = 3'd2;
      `CMD_PULSE_TRIG:     idx = 3'd1;
      `CMD_PULSE_READOUT:  idx = 3'd0;
      default:             known = 1'b0;
    endcase
    if (!known)
      stop_on_error($sformatf("Case %s names a word that is not a pulse command", name));
    send_word(1'b1, word);
    // Active from the accepting edge on
    if (!pulse_on[idx])
      stop_on_error($sformatf("Pulse of case %s did not start at the accepting edge", name));
    len = 0;
    while (pulse_on[idx])
    begin
      if (len == TIMEOUT)
        stop_on_error($sformatf("Pulse of case %s never ended", name));
      len++;
      @(posedge clk);
      cmd_valid <= (len == 1); // Same word again while the pulse runs
      cmd_word  <= word;
      @(negedge clk);
    end
    check_pulse_len(name, exp_len, len);
  endtask

  // Unknown words and invalid cycles must leave every output alone
  task automatic check_no_effect(input string name, input logic valid, input cmd_word_t word);
    trig_cfg_t  trig_before;
    run_ctrl_t  run_before;
    dac_cfg_t   dac_before;
    probe_vec_t ana_before;
    probe_vec_t thr_before;
    probe_vec_t res_before;
    int         cnt;
    trig_before = trig_cfg;
    run_before  = run_ctrl;
    dac_before  = dac_cfg;
    ana_before  = probe_vec_t'(probe_ana);
    thr_before  = probe_vec_t'(probe_thr);
    res_before  = probe_vec_t'(probe_res);
    send_word(valid, word);
    check_trig_cfg(name, trig_before, trig_cfg);
    check_run_ctrl(name, run_before, run_ctrl);
    check_dac_cfg(name, dac_before, dac_cfg);
    check_probe(name, ana_before, probe_vec_t'(probe_ana));
    check_probe(name, thr_before, probe_vec_t'(probe_thr));
    check_probe(name, res_before, probe_vec_t'(probe_res));
    count_active_cycles(cnt);
    check_pulse_len(name, 0, cnt);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial
  begin
    int          fd;
    int          n;
    int          line_no;
    int          cnt;
    string       line;
    string       kind;
    string       name;
    cmd_word_t   word;
    logic [63:0] expv;
    trig_cfg_t   trig_rst;
    run_ctrl_t   run_rst;
    dac_cfg_t    dac_rst;

    void'($urandom(32'he836_742d));
    cmd_valid = 1'b0;
    cmd_word  = '0;
    reset_n   = 1'b0;
    repeat (4) @(posedge clk);
    reset_n <= 1'b1;
    @(negedge clk);

    // Values after reset
    trig_rst.trig_mode    = 4'b0001;
    trig_rst.inside_time  = 8'd1;
    trig_rst.hold_delay   = 12'd1560;
    trig_rst.valid_ta     = 4'b1111;
    run_rst               = '0;
    run_rst.start_acq     = 1'b1;
    run_rst.tdc_on        = 1'b1;
    dac_rst.ta_thr_12     = 10'h3FF;
    dac_rst.ta_thr_34     = 10'h3FF;
    dac_rst.cali_dac      = 12'h500;
    dac_rst.sel_cali_ta   = 2'b00;
    dac_rst.feedback_cap  = 4'b1111;
    check_trig_cfg("reset", trig_rst, trig_cfg);
    check_run_ctrl("reset", run_rst, run_ctrl);
    check_dac_cfg("reset", dac_rst, dac_cfg);
    check_probe("reset", '0, probe_vec_t'(probe_ana));
    check_probe("reset", '0, probe_vec_t'(probe_thr));
    check_probe("reset", '0, probe_vec_t'(probe_res));
    count_active_cycles(cnt);
    check_pulse_len("reset", 0, cnt);

    fd = $fopen("cmd_cases.txt", "r");
    if (fd == 0)
      stop_on_error("Could not open cmd_cases.txt for reading");
    line_no = 0;
    while ($fgets(line, fd) != 0)
    begin
      line_no++;
      if (line.len() < 3 || line.getc(0) == "#")
        continue; // Blank or comment line
      n = $sscanf(line, "%s %h %h", kind, word, expv);
      if (n != 3)
        stop_on_error($sformatf("Line %0d of cmd_cases.txt could not be read", line_no));
      name = $sformatf("%s_line%0d", kind, line_no);
      idle_gap();
      case (kind)
        "trig":
        begin
          send_word(1'b1, word);
          check_trig_cfg(name, trig_cfg_t'(expv[$bits(trig_cfg_t)-1:0]), trig_cfg);
        end
        "run":
        begin
          send_word(1'b1, word);
          check_run_ctrl(name, run_ctrl_t'(expv[$bits(run_ctrl_t)-1:0]), run_ctrl);
        end
        "dac":
        begin
          send_word(1'b1, word);
          check_dac_cfg(name, dac_cfg_t'(expv[$bits(dac_cfg_t)-1:0]), dac_cfg);
        end
        "ana", "thr", "res": probe_case(name, kind, word, int'(expv));
        "pulse":             pulse_case(name, word, int'(expv));
        "none":              check_no_effect(name, 1'b1, word);
        "idle":              check_no_effect(name, 1'b0, word);
        default:
          stop_on_error($sformatf("Line %0d has an unknown check kind %s", line_no, kind));
      endcase
    end
    $fclose(fd);
    if (dut.u_sva.err_count != 0)
      stop_on_error($sformatf("The bound checker saw %0d assertion failures",
                              dut.u_sva.err_count));
    else
    begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

// File: cmd_cases.txt
# Columns: check kind, control word (hex), expected value (hex)
# trig/run/dac expect the packed struct, probes the 1-based set bit, pulses the length
trig  AA02 201618F
trig  AA03 401618F
trig  AA04 801618F
trig  AA01 101618F
trig  AB5A 15A618F
trig  6ABC 15AABCF
trig  9205 15AABC5
run   00A1 29
run   FFB1 39
run   FFA0 31
run   F0F1 35
run   FD41 37
run   F900 36
run   00A0 16
run   FFB0 06
run   FFA1 0E
run   F0F0 0A
run   FD40 08
run   F901 09
dac   1001 200FFD402F
dac   4003 200C01403F
dac   5ABC 200C02AF0F
dac   ACA6 200C02AF06
dac   12D5 2ADC02AF26
ana   30C0 C0
ana   30C1 0
ana   3001 1
ana   3000 0
thr   3180 80
thr   3181 0
thr   3101 1
thr   3100 0
res   3440 40
res   3441 0
res   3401 1
res   3400 0
pulse 00B1 0A
pulse FFC0 11
pulse 00B2 0C
pulse FFD0 04
pulse FFE0 02
pulse FFE3 0C
none  0000 0
none  2345 0
none  AA05 0
none  FFB2 0
none  3200 0
none  7123 0
idle  AA02 0
idle  3005 0

// File: list.f
+incdir+.
cmd_pkg.sv
cmd_decoder.sv
trig_config_regs.sv
dac_config_regs.sv
probe_select.sv
pulse_gen.sv
cmd_interp_top.sv
cmd_sva.sv
cmd_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/1ps -j 0 \
  -f list.f --top-module cmd_tb -o cmd_tb_sim
./obj_dir/cmd_tb_sim | tee /dev/stderr | grep -F "Simulation finished: PASS" > /dev/null
